// ==== design/arb_cfg_pkg.sv ====
/*
  arbiter control register map and config struct
  max_stall of zero turns the starvation guard off
*/
`default_nettype none

package arb_cfg_pkg;

  localparam int unsigned STALL_W = 8;

  typedef logic [STALL_W-1:0] stall_cnt_t;

  // register map, one bit of address
  localparam int unsigned          CFG_ADDR_W     = 1;
  localparam logic [CFG_ADDR_W-1:0] CFG_SWAP_ADDR  = 1'b0;  // bit 0 of wdata
  localparam logic [CFG_ADDR_W-1:0] CFG_STALL_ADDR = 1'b1;  // full byte

  typedef struct packed {
    logic       swap_prio;  // 1: low side preferred
    stall_cnt_t max_stall;  // 0: guard disabled
  } arb_cfg_t;

endpackage

`default_nettype wire

// ==== design/arb_cfg_regs.sv ====
/*
  arbiter configuration registers, written by a single-cycle strobe
  a write at edge k steers arbitration from the next cycle on
  no read-back path
*/
`default_nettype none

module arb_cfg_regs
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   cfg_we,
  input  logic [arb_cfg_pkg::CFG_ADDR_W-1:0]     cfg_addr,
  input  arb_cfg_pkg::stall_cnt_t                cfg_wdata,
  output arb_cfg_pkg::arb_cfg_t                  cfg
);

  logic                    swap_q;       // side swap bit
  arb_cfg_pkg::stall_cnt_t max_stall_q;  // starvation limit

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      swap_q      <= 1'b0;  // high side preferred out of reset
      max_stall_q <= '0;    // guard off
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        arb_cfg_pkg::CFG_SWAP_ADDR:
        begin
          swap_q <= cfg_wdata[0];  // only lsb matters
        end
        arb_cfg_pkg::CFG_STALL_ADDR:
        begin
          max_stall_q <= cfg_wdata;
        end
      endcase
    end
  end

  // pack for the arbiter
  always_comb
  begin
    cfg.swap_prio = swap_q;
    cfg.max_stall = max_stall_q;
  end

endmodule

`default_nettype wire

// ==== design/shallow_arbiter.sv ====
/*
  fixed-priority merge of a high and a low requester per channel
  priority is global: any preferred request blocks the other side everywhere
  starvation guard lets the other side through once after max_stall cycles
  purely combinational req -> gnt, only the stall counter is registered
*/
`default_nettype none

module shallow_arbiter
#(
  parameter int unsigned NB_CHAN = tcdm_pkg::NB_CHAN
)
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear,
  input  arb_cfg_pkg::arb_cfg_t cfg,
  input  tcdm_pkg::tcdm_req_t   in_high  [NB_CHAN],
  input  tcdm_pkg::tcdm_req_t   in_low   [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t   rsp_high [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t   rsp_low  [NB_CHAN],
  output tcdm_pkg::tcdm_req_t   mem_req  [NB_CHAN],
  input  tcdm_pkg::tcdm_rsp_t   mem_rsp  [NB_CHAN]
);

  logic [NB_CHAN-1:0]      pref_req;     // preferred side, per channel
  logic [NB_CHAN-1:0]      other_req;    // non-preferred side
  logic                    high_sel;     // set when the high side owns the banks
  logic                    pref_any;
  logic                    other_any;
  logic                    guard_hit;    // starvation limit reached
  logic                    pref_any_eff;
  arb_cfg_pkg::stall_cnt_t stall_cnt;

  // swap exchanges which side counts as preferred
  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_side_map
    assign pref_req[ii]  = cfg.swap_prio ? in_low[ii].req  : in_high[ii].req;
    assign other_req[ii] = cfg.swap_prio ? in_high[ii].req : in_low[ii].req;
  end

  assign pref_any  = |pref_req;   // across all channels
  assign other_any = |other_req;

  // guard only active with a nonzero limit
  assign guard_hit    = (cfg.max_stall != '0) && (stall_cnt >= cfg.max_stall);
  assign pref_any_eff = pref_any & ~guard_hit;  // masked for one cycle

  // counts consecutive cycles where the other side loses
  // drops back to zero on the cycle the guard lets it through
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_cnt <= '0;
    end
    else if (clear)
    begin
      stall_cnt <= '0;
    end
    else if (pref_any_eff && other_any)
    begin
      if (stall_cnt != '1)  // saturate
        stall_cnt <= stall_cnt + 1'b1;
    end
    else
    begin
      stall_cnt <= '0;
    end
  end

  // other side only gets through once no preferred request is left anywhere
  // xor maps preferred/other back onto high/low
  assign high_sel = pref_any_eff ^ cfg.swap_prio;

  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_chan
    always_comb
    begin
      if (high_sel)
        mem_req[ii] = in_high[ii];  // bank idles if this high side has nothing
      else
        mem_req[ii] = in_low[ii];

      // grant to the winner only
      rsp_high[ii].gnt = high_sel & mem_rsp[ii].gnt;
      rsp_low[ii].gnt  = ~high_sel & mem_rsp[ii].gnt;

      // read data broadcast, id tells who it belongs to
      rsp_high[ii].r_data = mem_rsp[ii].r_data;
      rsp_low[ii].r_data  = mem_rsp[ii].r_data;
      rsp_high[ii].r_id   = mem_rsp[ii].r_id;
      rsp_low[ii].r_id    = mem_rsp[ii].r_id;
    end
  end

endmodule

`default_nettype wire

// ==== design/tcdm_bank.sv ====
/*
  single-port word SRAM model, 64 words, byte-enabled writes
  never stalls: gnt follows req in the same cycle
  read data and id appear one cycle after acceptance and hold until the next read
  memory contents are not reset
*/
`default_nettype none

module tcdm_bank
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::tcdm_req_t req,
  output tcdm_pkg::tcdm_rsp_t rsp
);

  tcdm_pkg::tcdm_data_t mem [2**tcdm_pkg::ADDR_W];
  tcdm_pkg::tcdm_data_t r_data_q;
  tcdm_pkg::tcdm_id_t   r_id_q;
  logic                 wr_en;
  logic                 rd_en;

  assign wr_en = req.req & ~req.wen;  // wen low means write
  assign rd_en = req.req & req.wen;

  // byte lanes written independently
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < tcdm_pkg::BE_W; b++)
      begin
        if (req.be[b])
          mem[req.add][b*8 +: 8] <= req.data[b*8 +: 8];
      end
    end
  end

  // read port, one cycle latency
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      r_data_q <= '0;
      r_id_q   <= '0;
    end
    else if (rd_en)
    begin
      r_data_q <= mem[req.add];
      r_id_q   <= req.id;
    end
  end

  assign rsp.gnt    = req.req;   // no bank conflicts, always granted
  assign rsp.r_data = r_data_q;
  assign rsp.r_id   = r_id_q;

endmodule

`default_nettype wire

// ==== design/tcdm_pkg.sv ====
/*
  tcdm channel widths and request/response structs
  word addressed, 64 words per bank, byte enables on 32-bit words
  wen = 1 means read, following the usual tcdm convention
*/
`default_nettype none

package tcdm_pkg;

  localparam int unsigned NB_CHAN = 2;   // default channel count
  localparam int unsigned ADDR_W  = 6;   // word address, 64 words
  localparam int unsigned DATA_W  = 32;
  localparam int unsigned BE_W    = 4;   // one enable per byte
  localparam int unsigned ID_W    = 4;

  typedef logic [ADDR_W-1:0] tcdm_addr_t;
  typedef logic [DATA_W-1:0] tcdm_data_t;
  typedef logic [BE_W-1:0]   tcdm_be_t;
  typedef logic [ID_W-1:0]   tcdm_id_t;

  // requester -> arbiter -> bank
  typedef struct packed {
    logic       req;
    logic       wen;    // 1 read, 0 write
    tcdm_addr_t add;
    tcdm_be_t   be;
    tcdm_data_t data;
    tcdm_id_t   id;
  } tcdm_req_t;

  // bank -> arbiter -> requester
  typedef struct packed {
    logic       gnt;
    tcdm_data_t r_data;  // valid the cycle after an accepted read
    tcdm_id_t   r_id;
  } tcdm_rsp_t;

endpackage

`default_nettype wire

// ==== design/tcdm_subsystem_top.sv ====
/*
  tcdm subsystem: config registers, shallow arbiter, one bank per channel
  each channel maps straight onto its own bank, no address interleaving
  grant in the request cycle, read data one cycle after acceptance
*/
`default_nettype none

module tcdm_subsystem_top
#(
  parameter int unsigned NB_CHAN = tcdm_pkg::NB_CHAN
)
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear,      // stall counter reset
  input  logic                                cfg_we,
  input  logic [arb_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr,
  input  arb_cfg_pkg::stall_cnt_t             cfg_wdata,
  input  tcdm_pkg::tcdm_req_t                 in_high  [NB_CHAN],
  input  tcdm_pkg::tcdm_req_t                 in_low   [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t                 rsp_high [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t                 rsp_low  [NB_CHAN]
);

  arb_cfg_pkg::arb_cfg_t cfg;
  tcdm_pkg::tcdm_req_t   mem_req [NB_CHAN];  // arbiter -> banks
  tcdm_pkg::tcdm_rsp_t   mem_rsp [NB_CHAN];  // banks -> arbiter

  arb_cfg_regs i_arb_cfg_regs (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .cfg_we    ( cfg_we    ),
    .cfg_addr  ( cfg_addr  ),
    .cfg_wdata ( cfg_wdata ),
    .cfg       ( cfg       )
  );

  shallow_arbiter #(
    .NB_CHAN ( NB_CHAN )
  ) i_shallow_arbiter (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .clear    ( clear    ),
    .cfg      ( cfg      ),
    .in_high  ( in_high  ),
    .in_low   ( in_low   ),
    .rsp_high ( rsp_high ),
    .rsp_low  ( rsp_low  ),
    .mem_req  ( mem_req  ),
    .mem_rsp  ( mem_rsp  )
  );

  // one bank behind each channel
  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_bank
    tcdm_bank i_tcdm_bank (
      .clk_i  ( clk_i       ),
      .rst_ni ( rst_ni      ),
      .req    ( mem_req[ii] ),
      .rsp    ( mem_rsp[ii] )
    );
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tcdm subsystem testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tcdm_subsystem -f tcdm_subsystem.f
out=$(./obj_dir/Vtb_tcdm_subsystem || true)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// ==== tcdm_subsystem.f ====
design/tcdm_pkg.sv
design/arb_cfg_pkg.sv
design/arb_cfg_regs.sv
design/shallow_arbiter.sv
design/tcdm_bank.sv
design/tcdm_subsystem_top.sv
verification/tcdm_subsystem_checker.sv
verification/tb_tcdm_subsystem.sv

// ==== verification/tb_tcdm_subsystem.sv ====
/*
  table driven testbench for the tcdm subsystem, two channels
  rows are driven 1 unit after the rising edge and checked 2 units later
  read data is checked in the row after the read was granted
*/
`default_nettype none

module tb_tcdm_subsystem;

  localparam int unsigned NCH = 2;

  typedef struct packed {
    logic                                cfg_we;
    logic [arb_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr;
    arb_cfg_pkg::stall_cnt_t             cfg_wdata;
    logic                                clear;
    tcdm_pkg::tcdm_req_t [NCH-1:0]       hi;
    tcdm_pkg::tcdm_req_t [NCH-1:0]       lo;
    logic [NCH-1:0]                      exp_h;   // expected high gnt, bit per channel
    logic [NCH-1:0]                      exp_l;
  } row_t;

  localparam tcdm_pkg::tcdm_req_t idle = '0;

  logic                               clk_i = 1'b0;
  logic                               rst_ni;
  logic                               clear;
  logic                               cfg_we;
  logic [arb_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr;
  arb_cfg_pkg::stall_cnt_t            cfg_wdata;
  tcdm_pkg::tcdm_req_t                in_high  [NCH];
  tcdm_pkg::tcdm_req_t                in_low   [NCH];
  tcdm_pkg::tcdm_rsp_t                rsp_high [NCH];
  tcdm_pkg::tcdm_rsp_t                rsp_low  [NCH];

  row_t                 rows [$];
  logic                 table_done = 1'b0;
  logic [31:0]          lfsr_q;
  tcdm_pkg::tcdm_data_t model [NCH][64];  // one image per bank, X until written
  logic [NCH-1:0]       pend_v = '0;       // read granted last row
  logic [NCH-1:0]       pend_hi;
  tcdm_pkg::tcdm_data_t pend_data [NCH];
  tcdm_pkg::tcdm_id_t   pend_id   [NCH];
  int                   errors = 0;
  int                   checks = 0;

  tcdm_subsystem_top #(
    .NB_CHAN ( NCH )
  ) i_tcdm_subsystem_top (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear     ( clear     ),
    .cfg_we    ( cfg_we    ),
    .cfg_addr  ( cfg_addr  ),
    .cfg_wdata ( cfg_wdata ),
    .in_high   ( in_high   ),
    .in_low    ( in_low    ),
    .rsp_high  ( rsp_high  ),
    .rsp_low   ( rsp_low   )
  );

  always #2 clk_i = ~clk_i;  // period 4

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rnd_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic tcdm_pkg::tcdm_req_t rd(input int add, input int id);
    tcdm_pkg::tcdm_req_t q;
    q     = '0;
    q.req = 1'b1;
    q.wen = 1'b1;  // read
    q.add = tcdm_pkg::tcdm_addr_t'(add);
    q.id  = tcdm_pkg::tcdm_id_t'(id);
    return q;
  endfunction

  function automatic tcdm_pkg::tcdm_req_t wr(input int add, input int id, input bit full);
    tcdm_pkg::tcdm_req_t q;
    q      = rd(add, id);
    q.wen  = 1'b0;
    q.data = rnd_bits(32);
    q.be   = full ? '1 : tcdm_pkg::tcdm_be_t'(rnd_bits(4));  // random lanes
    return q;
  endfunction

  task automatic add_row(input logic we, input logic ca, input int wd, input logic clr,
                         input tcdm_pkg::tcdm_req_t h0, input tcdm_pkg::tcdm_req_t h1,
                         input tcdm_pkg::tcdm_req_t l0, input tcdm_pkg::tcdm_req_t l1,
                         input logic [NCH-1:0] eh, input logic [NCH-1:0] el);
    rows.push_back('{we, ca, arb_cfg_pkg::stall_cnt_t'(wd), clr, {h1, h0}, {l1, l0}, eh, el});
  endtask

  task automatic build_table();
    lfsr_q = 32'h8cc4;
    add_row(0, 0, 0, 0, idle, idle, idle, idle, 2'b00, 2'b00);  // quiet after reset
    add_row(0, 0, 0, 0, wr(5, 1, 1), wr(9, 2, 1), idle, idle, 2'b11, 2'b00);
    add_row(0, 0, 0, 0, idle, idle, wr(5, 3, 0), wr(9, 4, 0), 2'b00, 2'b11);
    add_row(0, 0, 0, 0, rd(5, 5), idle, idle, rd(9, 8), 2'b01, 2'b00);  // ch0 high blocks ch1
    add_row(0, 0, 0, 0, idle, rd(9, 7), idle, rd(9, 8), 2'b10, 2'b00);  // ch1 contention
    add_row(0, 0, 0, 0, idle, idle, idle, rd(9, 8), 2'b00, 2'b10);      // low retries
    add_row(0, 0, 0, 0, idle, idle, wr(5, 9, 0), idle, 2'b00, 2'b01);
    add_row(0, 0, 0, 0, rd(5, 10), idle, idle, idle, 2'b01, 2'b00);
    add_row(0, 0, 0, 0, idle, wr(9, 15, 0), idle, idle, 2'b10, 2'b00);  // high side lanes
    add_row(1, arb_cfg_pkg::CFG_SWAP_ADDR, 1, 0, idle, idle, idle, idle, 2'b00, 2'b00);
    add_row(0, 0, 0, 0, idle, rd(9, 11), idle, rd(9, 12), 2'b00, 2'b10);  // low wins now
    add_row(0, 0, 0, 0, rd(5, 13), rd(9, 11), idle, rd(9, 14), 2'b00, 2'b10);
    add_row(0, 0, 0, 0, rd(5, 13), rd(9, 11), idle, idle, 2'b11, 2'b00);
    add_row(1, arb_cfg_pkg::CFG_SWAP_ADDR, 0, 0, idle, idle, idle, idle, 2'b00, 2'b00);
    add_row(1, arb_cfg_pkg::CFG_STALL_ADDR, 3, 0, idle, idle, idle, idle, 2'b00, 2'b00);
    // guard lets low through on every fourth contention cycle
    for (int k = 0; k < 8; k++)
      add_row(0, 0, 0, 0, idle, rd(9, 1), idle, rd(9, 2),
              (k % 4 == 3) ? 2'b00 : 2'b10, (k % 4 == 3) ? 2'b10 : 2'b00);
    // clear on the second row restarts the count
    for (int k = 0; k < 6; k++)
      add_row(0, 0, 0, (k == 1), idle, rd(9, 1), idle, rd(9, 2),
              (k == 5) ? 2'b00 : 2'b10, (k == 5) ? 2'b10 : 2'b00);
    add_row(0, 0, 0, 0, idle, idle, idle, idle, 2'b00, 2'b00);  // drains last read
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_row(input row_t r);
    cfg_we    = r.cfg_we;
    cfg_addr  = r.cfg_addr;
    cfg_wdata = r.cfg_wdata;
    clear     = r.clear;
    for (int ii = 0; ii < NCH; ii++)
    begin
      in_high[ii] = r.hi[ii];
      in_low[ii]  = r.lo[ii];
    end
  endtask

  // grants of this row, read data of the last one, then update the model
  task automatic check_row(input row_t r);
    tcdm_pkg::tcdm_req_t acc;
    tcdm_pkg::tcdm_rsp_t got;
    for (int ii = 0; ii < NCH; ii++)
    begin
      check_val($sformatf("ch%0d high gnt", ii), rsp_high[ii].gnt, r.exp_h[ii]);
      check_val($sformatf("ch%0d low gnt", ii), rsp_low[ii].gnt, r.exp_l[ii]);
      if (pend_v[ii])
      begin
        got = pend_hi[ii] ? rsp_high[ii] : rsp_low[ii];
        check_val($sformatf("ch%0d r_id", ii), got.r_id, pend_id[ii]);
        if (!$isunknown(pend_data[ii]))  // only fully written words
          check_val($sformatf("ch%0d r_data", ii), got.r_data, pend_data[ii]);
      end
      pend_v[ii] = 1'b0;
      acc = r.exp_h[ii] ? r.hi[ii] : r.lo[ii];
      if ((r.exp_h[ii] || r.exp_l[ii]) && acc.req)
      begin
        if (acc.wen)
        begin
          pend_v[ii]    = 1'b1;
          pend_hi[ii]   = r.exp_h[ii];
          pend_data[ii] = model[ii][acc.add];
          pend_id[ii]   = acc.id;
        end
        else
        begin
          for (int b = 0; b < tcdm_pkg::BE_W; b++)
            if (acc.be[b])
              model[ii][acc.add][b*8 +: 8] = acc.data[b*8 +: 8];  // merge lanes
        end
      end
    end
  endtask

  initial
  begin
    rst_ni    = 1'b0;
    clear     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    in_high   = '{default: '0};
    in_low    = '{default: '0};
    build_table();
    table_done = 1'b1;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    #2;
    for (int ii = 0; ii < NCH; ii++)
    begin
      check_val($sformatf("ch%0d reset r_data high", ii), rsp_high[ii].r_data, '0);
      check_val($sformatf("ch%0d reset r_data low", ii), rsp_low[ii].r_data, '0);
    end
    foreach (rows[r])
    begin
      @(posedge clk_i);
      #1 drive_row(rows[r]);
      #2 check_row(rows[r]);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog, sized from the table length
  initial
  begin
    wait (table_done);
    #((rows.size() + 20) * 4);
    $display("timeout: the row sequence did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tcdm_subsystem_checker.sv ====
/*
  concurrent checks on the shallow arbiter, attached by bind
  the guard check holds only while max_stall is nonzero
*/
`default_nettype none

module tcdm_subsystem_checker
#(
  parameter int unsigned NB_CHAN = tcdm_pkg::NB_CHAN
)
(
  input logic                    clk_i,
  input logic                    rst_ni,
  input arb_cfg_pkg::arb_cfg_t   cfg,
  input tcdm_pkg::tcdm_req_t     in_high  [NB_CHAN],
  input tcdm_pkg::tcdm_req_t     in_low   [NB_CHAN],
  input tcdm_pkg::tcdm_rsp_t     rsp_high [NB_CHAN],
  input tcdm_pkg::tcdm_rsp_t     rsp_low  [NB_CHAN],
  input arb_cfg_pkg::stall_cnt_t stall_cnt
);

  logic [NB_CHAN-1:0] other_req;  // non-preferred side, per channel
  logic [NB_CHAN-1:0] other_gnt;

  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_chan_chk
    assign other_req[ii] = cfg.swap_prio ? in_high[ii].req : in_low[ii].req;
    assign other_gnt[ii] = cfg.swap_prio ? rsp_high[ii].gnt : rsp_low[ii].gnt;

    one_winner: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(rsp_high[ii].gnt && rsp_low[ii].gnt))
      else $error("both sides granted on channel %0d", ii);

    high_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_high[ii].gnt |-> in_high[ii].req)
      else $error("high grant without request on channel %0d", ii);

    low_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_low[ii].gnt |-> in_low[ii].req)
      else $error("low grant without request on channel %0d", ii);
  end

  // at the limit the waiting side must get through
  guard_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg.max_stall != '0 && stall_cnt >= cfg.max_stall && |other_req) |-> |other_gnt)
    else $error("starvation guard did not release the other side");

endmodule

bind shallow_arbiter tcdm_subsystem_checker #(
  .NB_CHAN ( NB_CHAN )
) i_tcdm_subsystem_checker (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .cfg       ( cfg       ),
  .in_high   ( in_high   ),
  .in_low    ( in_low    ),
  .rsp_high  ( rsp_high  ),
  .rsp_low   ( rsp_low   ),
  .stall_cnt ( stall_cnt )
);

`default_nettype wire
